//--- source/div_pkg.sv
// Shared definitions for the multi-cycle integer divider.
// Imported by the RTL modules for the default width, FSM states and counter sizing.

package div_pkg;

  // Operand width used when a module is not given one
  localparam int DIV_DEFAULT_WIDTH = 32;

  // Controller states
  typedef enum logic {
    DIV_IDLE = 1'b0,
    DIV_RUN  = 1'b1
  } div_state_t;

  // Bits needed to count WIDTH iterations, from 0 up to WIDTH-1
  function automatic int step_count_width(input int width);
    int bits;
    bits = $clog2(width);
    if (bits < 1) begin
      bits = 1;
    end
    return bits;
  endfunction

endpackage

//--- source/div_control.sv
// Divider FSM: accepts a start strobe, sequences the iterations and pulses done.
// Starts seen while an operation is running are dropped.

module div_control import div_pkg::*; #(
  parameter int WIDTH = DIV_DEFAULT_WIDTH
) (
  input  logic clk,
  input  logic reset,
  input  logic go,
  input  logic dividend_zero,
  input  logic last_step,
  output logic load,
  output logic running,
  output logic done
);

  div_state_t state;
  div_state_t state_next;
  logic       done_next;

  // Start is only taken when idle
  assign load    = go && (state == DIV_IDLE);
  assign running = (state == DIV_RUN);

  always_comb begin
    state_next = state;
    done_next  = 1'b0;
    case (state)
      DIV_IDLE: begin
        if (load) begin
          if (dividend_zero) begin
            // Nothing to iterate, result is already zero
            done_next = 1'b1;
          end else begin
            state_next = DIV_RUN;
          end
        end
      end
      DIV_RUN: begin
        if (last_step) begin
          state_next = DIV_IDLE;
          done_next  = 1'b1;
        end
      end
      default: begin
        state_next = DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= DIV_IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_next;
      done  <= done_next;
    end
  end

endmodule

//--- source/div_step_counter.sv
// Iteration counter for the divider.
// Cleared on load, advanced each running cycle, flags the final iteration.

module div_step_counter import div_pkg::*; #(
  parameter int WIDTH = DIV_DEFAULT_WIDTH
) (
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  logic running,
  output logic last_step
);

  typedef logic [step_count_width(WIDTH)-1:0] count_t;

  localparam count_t LAST_COUNT = count_t'(WIDTH - 1);

  count_t count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= '0;
    end else if (running) begin
      count <= count + count_t'(1);
    end
  end

  // High during the WIDTH-th running cycle
  assign last_step = running && (count == LAST_COUNT);

endmodule

//--- source/div_datapath.sv
// Restoring shift-and-subtract core on unsigned magnitudes.
// One quotient bit is produced per running cycle; results hold while idle.

module div_datapath import div_pkg::*; #(
  parameter int WIDTH = DIV_DEFAULT_WIDTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             load,
  input  logic             running,
  input  logic [WIDTH-1:0] dividend_mag,
  input  logic [WIDTH-1:0] divisor_mag,
  output logic [WIDTH-1:0] quotient_mag,
  output logic [WIDTH-1:0] remainder_mag
);

  typedef logic [WIDTH-1:0] word_t;

  word_t            divisor_reg;
  logic [WIDTH:0]   shifted;
  logic [WIDTH+1:0] trial;
  logic             fits;
  word_t            remainder_next;
  word_t            quotient_next;

  // Bring the next dividend bit into the partial remainder
  assign shifted = {remainder_mag, quotient_mag[WIDTH-1]};

  // Trial subtraction, top bit is the borrow
  assign trial = {1'b0, shifted} - {2'b00, divisor_reg};
  assign fits  = !trial[WIDTH+1];

  assign remainder_next = fits ? trial[WIDTH-1:0] : shifted[WIDTH-1:0];
  assign quotient_next  = {quotient_mag[WIDTH-2:0], fits};

  always_ff @(posedge clk) begin
    if (reset) begin
      quotient_mag  <= '0;
      remainder_mag <= '0;
    end else if (load) begin
      quotient_mag  <= dividend_mag;
      remainder_mag <= '0;
    end else if (running) begin
      quotient_mag  <= quotient_next;
      remainder_mag <= remainder_next;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      divisor_reg <= divisor_mag;
    end
  end

endmodule

//--- source/div_sign_adjust.sv
// Sign handling around the unsigned divider core.
// Forms operand magnitudes, keeps the operand signs and fixes up result signs.
// Remainder takes the sign of the divisor.

module div_sign_adjust import div_pkg::*; #(
  parameter int WIDTH = DIV_DEFAULT_WIDTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             load,
  input  logic             signed_mode,
  input  logic [WIDTH-1:0] dividend,
  input  logic [WIDTH-1:0] divisor,
  input  logic [WIDTH-1:0] quotient_mag,
  input  logic [WIDTH-1:0] remainder_mag,
  output logic [WIDTH-1:0] dividend_mag,
  output logic [WIDTH-1:0] divisor_mag,
  output logic             dividend_zero,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder
);

  typedef logic [WIDTH-1:0] word_t;

  logic  dividend_neg;
  logic  divisor_neg;
  logic  dividend_sign;
  logic  divisor_sign;
  logic  different_signs;
  word_t divisor_save;
  word_t remainder_mid;

  // Sign bits only count in signed mode
  assign dividend_neg = signed_mode && dividend[WIDTH-1];
  assign divisor_neg  = signed_mode && divisor[WIDTH-1];

  // Most negative value maps onto itself, which is its correct unsigned magnitude
  assign dividend_mag = dividend_neg ? word_t'(-dividend) : dividend;
  assign divisor_mag  = divisor_neg ? word_t'(-divisor) : divisor;

  assign dividend_zero = (dividend_mag == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      dividend_sign <= 1'b0;
      divisor_sign  <= 1'b0;
    end else if (load) begin
      dividend_sign <= dividend_neg;
      divisor_sign  <= divisor_neg;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      divisor_save <= divisor_mag;
    end
  end

  assign different_signs = dividend_sign ^ divisor_sign;

  assign quotient = different_signs ? word_t'(-quotient_mag) : quotient_mag;

  // Mixed signs with a nonzero remainder wrap into the divisor's range
  assign remainder_mid = (different_signs && (remainder_mag != '0))
                         ? word_t'(divisor_save - remainder_mag)
                         : remainder_mag;

  assign remainder = divisor_sign ? word_t'(-remainder_mid) : remainder_mid;

endmodule

//--- source/int_divider.sv
// Multi-cycle integer divider, signed or unsigned per operation.
// Pulse go with the operands; quotient and remainder are valid when done pulses.

module int_divider import div_pkg::*; #(
  parameter int WIDTH = DIV_DEFAULT_WIDTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             go,
  input  logic             signed_mode,
  input  logic [WIDTH-1:0] dividend,
  input  logic [WIDTH-1:0] divisor,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder,
  output logic             busy,
  output logic             done
);

  logic             load;
  logic             last_step;
  logic             dividend_zero;
  logic [WIDTH-1:0] dividend_mag;
  logic [WIDTH-1:0] divisor_mag;
  logic [WIDTH-1:0] quotient_mag;
  logic [WIDTH-1:0] remainder_mag;

  // The FSM run state is the busy indication
  div_control #(
    .WIDTH(WIDTH)
  ) div_control_inst (
    .clk          (clk),
    .reset        (reset),
    .go           (go),
    .dividend_zero(dividend_zero),
    .last_step    (last_step),
    .load         (load),
    .running      (busy),
    .done         (done)
  );

  div_step_counter #(
    .WIDTH(WIDTH)
  ) div_step_counter_inst (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .running  (busy),
    .last_step(last_step)
  );

  div_datapath #(
    .WIDTH(WIDTH)
  ) div_datapath_inst (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .running      (busy),
    .dividend_mag (dividend_mag),
    .divisor_mag  (divisor_mag),
    .quotient_mag (quotient_mag),
    .remainder_mag(remainder_mag)
  );

  div_sign_adjust #(
    .WIDTH(WIDTH)
  ) div_sign_adjust_inst (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .signed_mode  (signed_mode),
    .dividend     (dividend),
    .divisor      (divisor),
    .quotient_mag (quotient_mag),
    .remainder_mag(remainder_mag),
    .dividend_mag (dividend_mag),
    .divisor_mag  (divisor_mag),
    .dividend_zero(dividend_zero),
    .quotient     (quotient),
    .remainder    (remainder)
  );

endmodule

//--- bench/int_divider_tb.sv
// Self-checking testbench for the multi-cycle integer divider.
// Runs a table of fixed and LFSR-generated operations and checks results and timing.

module int_divider_tb;

  localparam int WIDTH      = 32;
  localparam int NUM_FIXED  = 16;
  localparam int NUM_RANDOM = 16;
  localparam int NUM_TESTS  = NUM_FIXED + NUM_RANDOM;
  localparam int TIMEOUT    = (16 + NUM_TESTS * (WIDTH + 4)) * 8;

  typedef logic [WIDTH-1:0] word_t;

  logic  clk = 1'b0;
  logic  reset;
  logic  go;
  logic  signed_mode;
  word_t dividend;
  word_t divisor;
  word_t quotient;
  word_t remainder;
  logic  busy;
  logic  done;

  // Stimulus and expected values
  string test_name     [NUM_TESTS];
  logic  tbl_signed    [NUM_TESTS];
  word_t tbl_dividend  [NUM_TESTS];
  word_t tbl_divisor   [NUM_TESTS];
  word_t tbl_quotient  [NUM_TESTS];
  word_t tbl_remainder [NUM_TESTS];
  logic  tbl_interrupt [NUM_TESTS];

  int          fill_count = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [31:0] lfsr_state = 32'h628b184c;

  int_divider #(
    .WIDTH(WIDTH)
  ) int_divider_inst (
    .clk        (clk),
    .reset      (reset),
    .go         (go),
    .signed_mode(signed_mode),
    .dividend   (dividend),
    .divisor    (divisor),
    .quotient   (quotient),
    .remainder  (remainder),
    .busy       (busy),
    .done       (done)
  );

  always #4 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic word_t random_bits(input int count);
    word_t value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[WIDTH-2:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Truncating division on magnitudes; remainder follows the divisor's sign
  task automatic expected_result(input logic sm, input word_t a, input word_t b,
                                 output word_t q, output word_t r);
    logic  a_neg;
    logic  b_neg;
    word_t am;
    word_t bm;
    word_t qm;
    word_t rm;
    word_t mid;
    a_neg = sm && a[WIDTH-1];
    b_neg = sm && b[WIDTH-1];
    am = a_neg ? -a : a;
    bm = b_neg ? -b : b;
    if (am == '0) begin
      // Early finish leaves both results at zero
      qm = '0;
      rm = '0;
    end else if (bm == '0) begin
      qm = '1;
      rm = am;
    end else begin
      qm = am / bm;
      rm = am % bm;
    end
    q = (a_neg != b_neg) ? -qm : qm;
    mid = ((a_neg != b_neg) && (rm != '0)) ? bm - rm : rm;
    r = b_neg ? -mid : mid;
  endtask

  task automatic add_entry(input string name, input logic sm, input word_t a, input word_t b,
                           input word_t q, input word_t r, input logic interrupt);
    test_name[fill_count]     = name;
    tbl_signed[fill_count]    = sm;
    tbl_dividend[fill_count]  = a;
    tbl_divisor[fill_count]   = b;
    tbl_quotient[fill_count]  = q;
    tbl_remainder[fill_count] = r;
    tbl_interrupt[fill_count] = interrupt;
    fill_count++;
  endtask

  task automatic fill_table();
    word_t a;
    word_t b;
    word_t q;
    word_t r;
    word_t shift;
    logic  sm;
    add_entry("u_100_by_7", 0, 32'd100, 32'd7, 32'd14, 32'd2, 0);
    add_entry("u_max_by_3", 0, 32'hffffffff, 32'd3, 32'h55555555, 32'd0, 0);
    add_entry("u_small_by_big", 0, 32'd5, 32'd9, 32'd0, 32'd5, 0);
    add_entry("u_top_bit_by_3", 0, 32'h80000000, 32'd3, 32'h2aaaaaaa, 32'd2, 0);
    add_entry("s_pos_by_pos", 1, 32'd7, 32'd2, 32'd3, 32'd1, 0);
    add_entry("s_neg_by_pos", 1, 32'hfffffff9, 32'd2, 32'hfffffffd, 32'd1, 0);
    add_entry("s_pos_by_neg", 1, 32'd7, 32'hfffffffe, 32'hfffffffd, 32'hffffffff, 0);
    add_entry("s_neg_by_neg", 1, 32'hfffffff9, 32'hfffffffe, 32'd3, 32'hffffffff, 0);
    add_entry("s_exact_mixed", 1, 32'hfffffff4, 32'd4, 32'hfffffffd, 32'd0, 0);
    add_entry("u_zero_dividend", 0, 32'd0, 32'd5, 32'd0, 32'd0, 0);
    add_entry("s_zero_dividend", 1, 32'd0, 32'hfffffffb, 32'd0, 32'd0, 0);
    add_entry("u_zero_divisor", 0, 32'h1234, 32'd0, 32'hffffffff, 32'h1234, 0);
    add_entry("s_zero_divisor_pos", 1, 32'd5, 32'd0, 32'hffffffff, 32'd5, 0);
    add_entry("s_zero_divisor_neg", 1, 32'hfffffffb, 32'd0, 32'd1, 32'hfffffffb, 0);
    add_entry("s_min_by_minus_one", 1, 32'h80000000, 32'hffffffff, 32'h80000000, 32'd0, 0);
    add_entry("u_ignored_go", 0, 32'd1003, 32'd10, 32'd100, 32'd3, 1);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      sm    = random_bits(1) != '0;
      a     = random_bits(WIDTH);
      b     = random_bits(WIDTH);
      shift = random_bits(5);
      b     = b >> shift;
      expected_result(sm, a, b, q, r);
      add_entry($sformatf("rand_%0d", i), sm, a, b, q, r, 0);
    end
  endtask

  task automatic compare_value(input string name, input string what,
                               input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("** Error: %s %s expected %h actual %h", name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic run_test(input int idx);
    int   edges;
    int   expect_edges;
    int   hold;
    int   errors_before;
    logic expect_busy;
    errors_before = errors;
    expect_edges  = (tbl_dividend[idx] == '0) ? 0 : WIDTH;
    expect_busy   = (expect_edges != 0);
    hold          = tbl_interrupt[idx] ? 4 : 1;
    @(posedge clk);
    go          <= 1'b1;
    signed_mode <= tbl_signed[idx];
    dividend    <= tbl_dividend[idx];
    divisor     <= tbl_divisor[idx];
    @(posedge clk);
    go    <= 1'b0;
    edges = 0;
    @(negedge clk);
    compare_value(test_name[idx], "busy after start", word_t'(expect_busy), word_t'(busy));
    while (done !== 1'b1 && edges < WIDTH + 2) begin
      @(posedge clk);
      edges++;
      // Second start with other operands that must be dropped
      if (tbl_interrupt[idx] && edges == WIDTH / 2) begin
        go       <= 1'b1;
        dividend <= ~tbl_dividend[idx];
        divisor  <= tbl_divisor[idx] + 1;
      end else begin
        go <= 1'b0;
      end
      @(negedge clk);
    end
    if (done !== 1'b1) begin
      $display("Test %s: done never rose within %0d edges of the start", test_name[idx], edges);
      errors++;
    end else begin
      compare_value(test_name[idx], "edges to done", word_t'(expect_edges), word_t'(edges));
      compare_value(test_name[idx], "quotient", tbl_quotient[idx], quotient);
      compare_value(test_name[idx], "remainder", tbl_remainder[idx], remainder);
      compare_value(test_name[idx], "busy at done", '0, word_t'(busy));
      for (int h = 0; h < hold; h++) begin
        @(negedge clk);
        compare_value(test_name[idx], "done after pulse", '0, word_t'(done));
        compare_value(test_name[idx], "busy while idle", '0, word_t'(busy));
        compare_value(test_name[idx], "held quotient", tbl_quotient[idx], quotient);
        compare_value(test_name[idx], "held remainder", tbl_remainder[idx], remainder);
      end
    end
    tests_run++;
    if (errors == errors_before) begin
      $display("ok      %s", test_name[idx]);
    end else begin
      tests_failed++;
      $display("failed  %s", test_name[idx]);
    end
  endtask

  initial begin
    int errors_before;
    reset       <= 1'b1;
    go          <= 1'b0;
    signed_mode <= 1'b0;
    dividend    <= '0;
    divisor     <= '0;
    fill_table();
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    errors_before = errors;
    compare_value("reset", "busy", '0, word_t'(busy));
    compare_value("reset", "done", '0, word_t'(done));
    compare_value("reset", "quotient", '0, quotient);
    compare_value("reset", "remainder", '0, remainder);
    tests_run++;
    if (errors == errors_before) begin
      $display("ok      reset");
    end else begin
      tests_failed++;
      $display("failed  reset");
    end
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(i);
    end
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- tb.f
source/div_pkg.sv
source/div_control.sv
source/div_step_counter.sv
source/div_datapath.sv
source/div_sign_adjust.sv
source/int_divider.sv
bench/int_divider_tb.sv

//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall
TOP        = int_divider_tb
RTL_TOP    = int_divider
FILELIST   = tb.f
OBJ_DIR    = obj_dir
LOG        = sim.log

SOURCES   = $(shell cat $(FILELIST))
RTL_FILES = $(filter source/%,$(SOURCES))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
